// File: Makefile
# Verilator build and regression run for the fetch unit

SIM := obj_dir/Vfetch_tb
SRCS := $(shell cat project.f)

.PHONY: all run clean

all: run

# Simulator binary, rebuilt when a listed source or the list changes
$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert --top-module fetch_tb -f project.f

# Pass or fail is decided by the log, not by the exit status
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/fetch_pkg.sv
// Shared widths, bit positions, limits and types for the AXI-lite instruction fetch unit
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and instruction widths
	//////////////////////////////////////////////////////////////////////
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int INSN_W = 32;

	// Words requested but not yet handed to the output stage
	localparam int FETCH_LIMIT = 16;

	//////////////////////////////////////////////////////////////////////
	// Derived positions and counter widths
	//////////////////////////////////////////////////////////////////////
	// Byte select bits within one bus word
	localparam int AXIL_LSB = $clog2(DATA_W / 8);
	// Byte select bits within one instruction
	localparam int INSN_LSB = $clog2(INSN_W / 8);
	localparam int INSNS_PER_WORD = DATA_W / INSN_W;

	// FIFO depth is sized to the fetch limit
	localparam int LG_FIFO = $clog2(FETCH_LIMIT);
	// Outstanding counter with headroom well past the limit
	localparam int LG_DEPTH = LG_FIFO + 4;
	// Holds 0 up to INSNS_PER_WORD
	localparam int OUT_FILL_W = $clog2(INSNS_PER_WORD) + 1;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [INSN_W-1:0] insn_t;

	// Returned bus word, tagged with its bus error
	typedef struct packed {
		logic  err;
		word_t data;
	} fifo_entry_t;

endpackage

`default_nettype wire

// File: fetch/axil_fetch.sv
// Top level of the AXI-lite instruction fetch unit; connect the CPU fetch port and the bus here
`timescale 1ns/100ps
`default_nettype none

module axil_fetch
(
	input  wire                  S_AXI_ACLK,
	input  wire                  S_AXI_ARESETN,
	// CPU side
	input  wire                  i_cpu_reset,
	input  wire                  i_new_pc,
	input  wire                  i_clear_cache,
	input  wire                  i_ready,
	input  wire fetch_pkg::addr_t i_pc,
	output fetch_pkg::insn_t     o_insn,
	output fetch_pkg::addr_t     o_pc,
	output logic                 o_valid,
	output logic                 o_illegal,
	// AXI-lite read channels
	output logic                 o_m_axi_arvalid,
	input  wire                  i_m_axi_arready,
	output fetch_pkg::addr_t     o_m_axi_araddr,
	input  wire                  i_m_axi_rvalid,
	input  wire fetch_pkg::word_t i_m_axi_rdata,
	input  wire [1:0]            i_m_axi_rresp
);

	logic restart;
	logic fifo_wr;
	logic fifo_rd;
	logic fifo_empty;
	logic pop;
	logic hold;
	fetch_pkg::fifo_entry_t wr_entry;
	fetch_pkg::fifo_entry_t rd_entry;

	// SLVERR and DECERR both carry the upper RRESP bit
	assign wr_entry = '{err: i_m_axi_rresp[1], data: i_m_axi_rdata};

	// Address channel, flush and throttle
	fetch_request u_request (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.S_AXI_ARESETN  (S_AXI_ARESETN),
		.i_cpu_reset    (i_cpu_reset),
		.i_new_pc       (i_new_pc),
		.i_clear_cache  (i_clear_cache),
		.i_pc           (i_pc),
		.i_m_axi_arready(i_m_axi_arready),
		.i_m_axi_rvalid (i_m_axi_rvalid),
		.i_pop          (pop),
		.i_hold         (hold),
		.o_m_axi_arvalid(o_m_axi_arvalid),
		.o_m_axi_araddr (o_m_axi_araddr),
		.o_restart      (restart),
		.o_fifo_wr      (fifo_wr)
	);

	// Returned words waiting for the output stage
	fetch_fifo u_fifo (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_restart    (restart),
		.i_wr         (fifo_wr),
		.i_rd         (fifo_rd),
		.i_entry      (wr_entry),
		.o_entry      (rd_entry),
		.o_empty      (fifo_empty)
	);

	// Word to instruction split and CPU handshake
	fetch_unpack u_unpack (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_restart    (restart),
		.i_new_pc     (i_new_pc),
		.i_pc         (i_pc),
		.i_ready      (i_ready),
		.i_entry      (rd_entry),
		.i_empty      (fifo_empty),
		.o_rd         (fifo_rd),
		.o_pop        (pop),
		.o_hold       (hold),
		.o_valid      (o_valid),
		.o_illegal    (o_illegal),
		.o_insn       (o_insn),
		.o_pc         (o_pc)
	);

endmodule

`default_nettype wire

// File: fetch/fetch_fifo.sv
// Synchronous FIFO of returned bus words with their error bit, between bus and output stage
`timescale 1ns/100ps
`default_nettype none

module fetch_fifo
(
	input  wire                         S_AXI_ACLK,
	input  wire                         S_AXI_ARESETN,
	input  wire                         i_restart,
	input  wire                         i_wr,
	input  wire                         i_rd,
	input  wire fetch_pkg::fifo_entry_t i_entry,
	output fetch_pkg::fifo_entry_t      o_entry,
	output logic                        o_empty
);

	fetch_pkg::fifo_entry_t mem [2**fetch_pkg::LG_FIFO];
	// Extra top bit tells full from empty
	logic [fetch_pkg::LG_FIFO:0] wr_ptr;
	logic [fetch_pkg::LG_FIFO:0] rd_ptr;
	logic full;
	logic do_wr;
	logic do_rd;

	assign o_empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr == {~rd_ptr[fetch_pkg::LG_FIFO], rd_ptr[fetch_pkg::LG_FIFO-1:0]});
	assign do_wr = i_wr && !full;
	assign do_rd = i_rd && !o_empty;

	//////////////////////////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_restart)
			wr_ptr <= '0;
		else if (do_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_restart)
			rd_ptr <= '0;
		else if (do_rd)
			rd_ptr <= rd_ptr + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (do_wr)
			mem[wr_ptr[fetch_pkg::LG_FIFO-1:0]] <= i_entry;
	end

	// Head of queue read without a register stage
	assign o_entry = mem[rd_ptr[fetch_pkg::LG_FIFO-1:0]];

	// Request throttle upstream must keep this from ever happening
	a_no_overflow: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN || i_restart)
		!(i_wr && full));

endmodule

`default_nettype wire

// File: fetch/fetch_request.sv
// Read-address side of the fetch unit; issues sequential word requests and discards stale replies
`timescale 1ns/100ps
`default_nettype none

module fetch_request
(
	input  wire                   S_AXI_ACLK,
	input  wire                   S_AXI_ARESETN,
	input  wire                   i_cpu_reset,
	input  wire                   i_new_pc,
	input  wire                   i_clear_cache,
	input  wire fetch_pkg::addr_t i_pc,
	input  wire                   i_m_axi_arready,
	input  wire                   i_m_axi_rvalid,
	input  wire                   i_pop,
	input  wire                   i_hold,
	output logic                  o_m_axi_arvalid,
	output fetch_pkg::addr_t      o_m_axi_araddr,
	output logic                  o_restart,
	output logic                  o_fifo_wr
);

	logic restart;
	logic ar_accept;
	logic [fetch_pkg::LG_DEPTH:0] outstanding;
	logic [fetch_pkg::LG_DEPTH:0] next_outstanding;
	logic [fetch_pkg::LG_DEPTH:0] flush_count;
	logic [fetch_pkg::LG_DEPTH:0] new_flush_count;
	logic flushing;
	logic flush_request;
	logic full_bus;
	logic pending_new_pc;
	fetch_pkg::addr_t pending_pc;
	logic [fetch_pkg::LG_DEPTH-1:0] fill;
	logic [fetch_pkg::LG_DEPTH:0] committed;
	logic throttle;

	// Any of these drops everything buffered
	assign restart = i_cpu_reset || i_clear_cache || i_new_pc;
	assign o_restart = restart;
	// Replies still owed to an old stream never reach the FIFO
	assign o_fifo_wr = i_m_axi_rvalid && !flushing;
	assign ar_accept = o_m_axi_arvalid && i_m_axi_arready;

	//////////////////////////////////////////////////////////////////////
	// Outstanding requests on the bus
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case ({ar_accept, i_m_axi_rvalid})
		2'b10: next_outstanding = outstanding + 1'b1;
		2'b01: next_outstanding = outstanding - 1'b1;
		default: next_outstanding = outstanding;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			outstanding <= '0;
			full_bus <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			// One slot kept back so the counter cannot wrap
			full_bus <= (next_outstanding >= {1'b0, {fetch_pkg::LG_DEPTH{1'b1}}});
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Flush of replies from before a redirect
	//////////////////////////////////////////////////////////////////////
	// Stalled request still counts as it cannot be withdrawn
	assign new_flush_count = outstanding
		+ (fetch_pkg::LG_DEPTH+1)'(o_m_axi_arvalid)
		- (fetch_pkg::LG_DEPTH+1)'(i_m_axi_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			flush_count <= '0;
			flushing <= 1'b0;
			flush_request <= 1'b0;
		end
		else if (restart)
		begin
			flush_count <= new_flush_count;
			flushing <= (new_flush_count != '0);
			flush_request <= o_m_axi_arvalid && !i_m_axi_arready;
		end
		else
		begin
			if (i_m_axi_rvalid && flushing)
			begin
				flush_count <= flush_count - 1'b1;
				flushing <= (flush_count > 1);
			end
			// Old request has gone out
			if (i_m_axi_arready)
				flush_request <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fill count and throttle
	//////////////////////////////////////////////////////////////////////
	// Words requested for the current stream and not yet popped
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || restart)
			fill <= '0;
		else
		begin
			case ({ar_accept && !flush_request, i_pop})
			2'b10: fill <= fill + 1'b1;
			2'b01: fill <= fill - 1'b1;
			default: fill <= fill;
			endcase
		end
	end

	// Includes the request on the bus and the word at the output
	assign committed = {1'b0, fill}
		+ (fetch_pkg::LG_DEPTH+1)'(o_m_axi_arvalid)
		+ (fetch_pkg::LG_DEPTH+1)'(i_hold);
	assign throttle = (committed >= (fetch_pkg::LG_DEPTH+1)'(fetch_pkg::FETCH_LIMIT));

	//////////////////////////////////////////////////////////////////////
	// Read-address channel
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_m_axi_arvalid <= 1'b0;
		else if (!o_m_axi_arvalid || i_m_axi_arready)
		begin
			// Fill restarts from zero on a new PC
			o_m_axi_arvalid <= i_new_pc || pending_new_pc || !throttle;
			if (i_cpu_reset || i_clear_cache || full_bus)
				o_m_axi_arvalid <= 1'b0;
		end
	end

	// New PC seen while a request was stuck on the bus
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_clear_cache)
			pending_new_pc <= 1'b0;
		else if (!o_m_axi_arvalid || i_m_axi_arready)
			pending_new_pc <= 1'b0;
		else if (i_new_pc)
			pending_new_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_pc <= i_pc;
	end

	// New PC, else pending PC, else next aligned word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_m_axi_arvalid || i_m_axi_arready)
		begin
			if (i_new_pc)
				o_m_axi_araddr <= i_pc;
			else if (pending_new_pc)
				o_m_axi_araddr <= pending_pc;
			else if (o_m_axi_arvalid)
				o_m_axi_araddr <= {o_m_axi_araddr[fetch_pkg::ADDR_W-1:fetch_pkg::AXIL_LSB] + 1'b1,
					{fetch_pkg::AXIL_LSB{1'b0}}};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////
	a_flush_flag: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		flushing == (flush_count != '0));

	// A request may not change or drop before it is taken
	a_ar_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_m_axi_arvalid && !i_m_axi_arready
		|=> o_m_axi_arvalid && $stable(o_m_axi_araddr));

endmodule

`default_nettype wire

// File: fetch/fetch_unpack.sv
// Output stage of the fetch unit; splits bus words into instructions and tracks the output PC
`timescale 1ns/100ps
`default_nettype none

module fetch_unpack
(
	input  wire                         S_AXI_ACLK,
	input  wire                         S_AXI_ARESETN,
	input  wire                         i_restart,
	input  wire                         i_new_pc,
	input  wire fetch_pkg::addr_t       i_pc,
	input  wire                         i_ready,
	input  wire fetch_pkg::fifo_entry_t i_entry,
	input  wire                         i_empty,
	output logic                        o_rd,
	output logic                        o_pop,
	output logic                        o_hold,
	output logic                        o_valid,
	output logic                        o_illegal,
	output fetch_pkg::insn_t            o_insn,
	output fetch_pkg::addr_t            o_pc
);

	// Instructions of the current word not yet taken
	logic [fetch_pkg::OUT_FILL_W-1:0] out_fill;
	fetch_pkg::word_t out_data;
	// Instruction index of the PC within its bus word
	logic [fetch_pkg::AXIL_LSB-fetch_pkg::INSN_LSB-1:0] shift;

	assign shift = o_pc[fetch_pkg::AXIL_LSB-1:fetch_pkg::INSN_LSB];

	// Read when idle, or when the last instruction leaves
	assign o_rd = !o_valid || (i_ready && (out_fill <= 1));
	assign o_pop = o_rd && !i_empty;
	// Word still sits at the output next cycle
	assign o_hold = o_valid && (!i_ready || (out_fill > 1));

	//////////////////////////////////////////////////////////////////////
	// Valid and remaining count
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_restart)
			o_valid <= 1'b0;
		else if (!o_valid || i_ready)
			o_valid <= o_pop || (out_fill > {1'b0, o_valid});
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_restart)
			out_fill <= '0;
		else if (o_rd)
		begin
			if (i_empty)
				out_fill <= '0;
			else if (o_valid)
				out_fill <= fetch_pkg::OUT_FILL_W'(fetch_pkg::INSNS_PER_WORD);
			else
				// First word after a redirect may start mid-word
				out_fill <= fetch_pkg::OUT_FILL_W'(fetch_pkg::INSNS_PER_WORD)
					- fetch_pkg::OUT_FILL_W'(shift);
		end
		else if (i_ready && (out_fill != '0))
			out_fill <= out_fill - 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Output word and instruction
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_rd)
		begin
			if (o_valid)
				out_data <= i_entry.data;
			else
				// Skip instructions ahead of an unaligned start
				out_data <= i_entry.data >> (fetch_pkg::INSN_W * shift);
		end
		else if (i_ready)
			out_data <= out_data >> fetch_pkg::INSN_W;
	end

	assign o_insn = out_data[fetch_pkg::INSN_W-1:0];

	// Bus error sticks until the next restart
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_restart)
			o_illegal <= 1'b0;
		else if (!o_illegal && o_pop)
			o_illegal <= i_entry.err;
	end

	// PC frozen on the faulting instruction
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			o_pc <= i_pc;
		else if (o_valid && i_ready && !o_illegal)
			o_pc <= {o_pc[fetch_pkg::ADDR_W-1:fetch_pkg::INSN_LSB] + 1'b1,
				{fetch_pkg::INSN_LSB{1'b0}}};
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////
	a_valid_fill: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_valid == (out_fill != '0));

	// CPU sees a steady instruction until it takes it
	a_out_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_valid && !i_ready && !i_restart
		|=> o_valid && $stable(o_insn) && $stable(o_pc) && $stable(o_illegal));

endmodule

`default_nettype wire

// File: project.f
common/fetch_pkg.sv
fetch/fetch_request.sv
fetch/fetch_fifo.sv
fetch/fetch_unpack.sv
fetch/axil_fetch.sv
tb/fetch_tb_mem.sv
tb/fetch_tb.sv

// File: tb/fetch_tb.sv
// Testbench top for the AXI-lite fetch unit; runs the directed tests and prints the verdict
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

	// Instruction at byte address A is A xor this key
	localparam logic [31:0] PATTERN_KEY = 32'h5a3c_96e1;
	localparam int SEED = 37601;
	localparam fetch_pkg::addr_t ERROR_BASE = 32'h0000_6000;
	// First instruction of the sixth word
	localparam fetch_pkg::addr_t ERR_ADDR = ERROR_BASE + 32'd40;

	// Instructions taken by each test
	localparam int N_SEQUENTIAL = 40;
	localparam int N_UNALIGNED = 8;
	localparam int N_REDIRECT_OLD = 6;
	localparam int N_REDIRECT_NEW = 12;
	localparam int N_ERR_LEAD = 10;
	localparam int N_ERR_STICKY = 5;
	localparam int N_BACKPRESSURE = 60;
	localparam int N_CLEAR_LEAD = 4;
	localparam int N_CLEAR_RESUME = 10;
	localparam int TOTAL_INSNS = N_SEQUENTIAL + N_UNALIGNED + N_REDIRECT_OLD + N_REDIRECT_NEW
		+ N_ERR_LEAD + N_ERR_STICKY + 1 + N_BACKPRESSURE + N_CLEAR_LEAD + N_CLEAR_RESUME;
	localparam int TIMEOUT_CYCLES = 6 * TOTAL_INSNS + 2000;

	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	logic cpu_reset;
	logic new_pc;
	logic clear_cache;
	logic ready;
	fetch_pkg::addr_t pc;
	fetch_pkg::insn_t insn;
	fetch_pkg::addr_t out_pc;
	logic valid;
	logic illegal;
	logic arvalid;
	logic arready;
	fetch_pkg::addr_t araddr;
	logic rvalid;
	fetch_pkg::word_t rdata;
	logic [1:0] rresp;
	// Memory model controls
	logic mem_random;
	logic err_en;
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;

	always #10 S_AXI_ACLK = ~S_AXI_ACLK;

	always @(posedge S_AXI_ACLK)
		cycle_count <= cycle_count + 1;

	axil_fetch dut (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.S_AXI_ARESETN  (S_AXI_ARESETN),
		.i_cpu_reset    (cpu_reset),
		.i_new_pc       (new_pc),
		.i_clear_cache  (clear_cache),
		.i_ready        (ready),
		.i_pc           (pc),
		.o_insn         (insn),
		.o_pc           (out_pc),
		.o_valid        (valid),
		.o_illegal      (illegal),
		.o_m_axi_arvalid(arvalid),
		.i_m_axi_arready(arready),
		.o_m_axi_araddr (araddr),
		.i_m_axi_rvalid (rvalid),
		.i_m_axi_rdata  (rdata),
		.i_m_axi_rresp  (rresp)
	);

	fetch_tb_mem #(.KEY(PATTERN_KEY)) u_mem (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_random     (mem_random),
		.i_err_en     (err_en),
		.i_err_addr   (ERR_ADDR),
		.i_arvalid    (arvalid),
		.i_araddr     (araddr),
		.o_arready    (arready),
		.o_rvalid     (rvalid),
		.o_rdata      (rdata),
		.o_rresp      (rresp)
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	function automatic fetch_pkg::insn_t expected_insn(input fetch_pkg::addr_t addr);
		return addr ^ PATTERN_KEY;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// One cycle pulse of the new PC from a falling edge
	task automatic start_fetch(input fetch_pkg::addr_t start_pc);
		ready = 1'b0;
		pc = start_pc;
		new_pc = 1'b1;
		cpu_reset = 1'b0;
		@(negedge S_AXI_ACLK);
		new_pc = 1'b0;
	endtask

	// Waits for valid and leaves the transfer to the rising edge in between
	task automatic take_insn(output fetch_pkg::addr_t got_pc, output fetch_pkg::insn_t got_insn,
		output logic got_illegal);
		ready = 1'b1;
		while (!valid)
			@(negedge S_AXI_ACLK);
		got_pc = out_pc;
		got_insn = insn;
		got_illegal = illegal;
		@(negedge S_AXI_ACLK);
	endtask

	task automatic expect_stream(input string name, input fetch_pkg::addr_t first_pc,
		input int count);
		fetch_pkg::addr_t exp_pc;
		fetch_pkg::addr_t got_pc;
		fetch_pkg::insn_t got_insn;
		logic got_illegal;
		exp_pc = first_pc;
		for (int i = 0; i < count; i++)
		begin
			take_insn(got_pc, got_insn, got_illegal);
			check({name, " pc"}, exp_pc, got_pc);
			check({name, " insn"}, expected_insn(exp_pc), got_insn);
			check({name, " illegal"}, 32'h0, 32'(got_illegal));
			exp_pc = exp_pc + 32'd4;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////
	task automatic sequential_test();
		start_fetch(32'h0000_1000);
		// First request goes out the cycle after the new PC
		check("sequential arvalid", 32'h1, 32'(arvalid));
		check("sequential araddr", 32'h0000_1000, araddr);
		expect_stream("sequential", 32'h0000_1000, N_SEQUENTIAL);
		ready = 1'b0;
	endtask

	// Second instruction of a word
	task automatic unaligned_test();
		start_fetch(32'h0000_2004);
		check("unaligned araddr", 32'h0000_2004, araddr);
		@(negedge S_AXI_ACLK);
		// Next request is the following aligned word
		check("unaligned next araddr", 32'h0000_2008, araddr);
		expect_stream("unaligned", 32'h0000_2004, N_UNALIGNED);
		ready = 1'b0;
	endtask

	// Redirect with requests on the bus and words buffered
	task automatic redirect_test();
		mem_random = 1'b1;
		start_fetch(32'h0000_3000);
		expect_stream("redirect old", 32'h0000_3000, N_REDIRECT_OLD);
		start_fetch(32'h0000_5100);
		expect_stream("redirect new", 32'h0000_5100, N_REDIRECT_NEW);
		ready = 1'b0;
	endtask

	task automatic error_test();
		fetch_pkg::addr_t got_pc;
		fetch_pkg::insn_t got_insn;
		logic got_illegal;
		mem_random = 1'b0;
		err_en = 1'b1;
		@(negedge S_AXI_ACLK);
		start_fetch(ERROR_BASE);
		expect_stream("error lead-in", ERROR_BASE, N_ERR_LEAD);
		// Flag rises on the error word and the PC stays there
		for (int i = 0; i < N_ERR_STICKY; i++)
		begin
			take_insn(got_pc, got_insn, got_illegal);
			check("error illegal", 32'h1, 32'(got_illegal));
			check("error pc", ERR_ADDR, got_pc);
		end
		start_fetch(32'h0000_7000);
		take_insn(got_pc, got_insn, got_illegal);
		check("error cleared illegal", 32'h0, 32'(got_illegal));
		check("error cleared pc", 32'h0000_7000, got_pc);
		ready = 1'b0;
		err_en = 1'b0;
	endtask

	task automatic backpressure_test();
		fetch_pkg::addr_t exp_pc;
		fetch_pkg::addr_t held_pc;
		fetch_pkg::insn_t held_insn;
		logic held;
		int taken;
		mem_random = 1'b1;
		start_fetch(32'h0000_8000);
		exp_pc = 32'h0000_8000;
		taken = 0;
		held = 1'b0;
		held_pc = '0;
		held_insn = '0;
		while (taken < N_BACKPRESSURE)
		begin
			// Stalled output must not move
			if (held)
			begin
				check("backpressure held valid", 32'h1, 32'(valid));
				check("backpressure held pc", held_pc, out_pc);
				check("backpressure held insn", held_insn, insn);
			end
			ready = 1'($urandom % 2);
			held = valid && !ready;
			held_pc = out_pc;
			held_insn = insn;
			if (valid && ready)
			begin
				check("backpressure pc", exp_pc, out_pc);
				check("backpressure insn", expected_insn(exp_pc), insn);
				exp_pc = exp_pc + 32'd4;
				taken++;
			end
			@(negedge S_AXI_ACLK);
		end
		ready = 1'b0;
	endtask

	task automatic clear_test();
		start_fetch(32'h0000_9000);
		expect_stream("clear lead-in", 32'h0000_9000, N_CLEAR_LEAD);
		ready = 1'b0;
		// Something buffered at the output before the clear
		while (!valid)
			@(negedge S_AXI_ACLK);
		clear_cache = 1'b1;
		@(negedge S_AXI_ACLK);
		clear_cache = 1'b0;
		check("clear valid", 32'h0, 32'(valid));
		start_fetch(32'h0000_9800);
		expect_stream("clear resume", 32'h0000_9800, N_CLEAR_RESUME);
		ready = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and timeout
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		void'($urandom(SEED));
		S_AXI_ARESETN = 1'b0;
		cpu_reset = 1'b1;
		new_pc = 1'b0;
		clear_cache = 1'b0;
		ready = 1'b0;
		pc = '0;
		mem_random = 1'b0;
		err_en = 1'b0;
		repeat (10) @(negedge S_AXI_ACLK);
		check("reset arvalid", 32'h0, 32'(arvalid));
		check("reset valid", 32'h0, 32'(valid));
		S_AXI_ARESETN = 1'b1;
		// CPU reset still held so nothing is fetched yet
		repeat (2) @(negedge S_AXI_ACLK);
		check("idle arvalid", 32'h0, 32'(arvalid));
		sequential_test();
		unaligned_test();
		redirect_test();
		error_test();
		backpressure_test();
		clear_test();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		while (cycle_count < TIMEOUT_CYCLES)
			@(posedge S_AXI_ACLK);
		$display("Timeout after %0d cycles, the DUT stopped delivering instructions",
			cycle_count);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/fetch_tb_mem.sv
// AXI-lite read slave model for the fetch testbench; answers in order with optional random timing
`timescale 1ns/100ps
`default_nettype none

module fetch_tb_mem
#(
	parameter logic [31:0] KEY = 32'h0
)
(
	input  wire                   S_AXI_ACLK,
	input  wire                   S_AXI_ARESETN,
	input  wire                   i_random,
	input  wire                   i_err_en,
	input  wire fetch_pkg::addr_t i_err_addr,
	input  wire                   i_arvalid,
	input  wire fetch_pkg::addr_t i_araddr,
	output logic                  o_arready,
	output logic                  o_rvalid,
	output fetch_pkg::word_t      o_rdata,
	output logic [1:0]            o_rresp
);

	// Accepted word addresses and the cycle each reply is due
	fetch_pkg::addr_t pend_addr[$];
	int pend_due[$];
	int cycle;

	// Lower address in the low half
	function automatic fetch_pkg::word_t word_for(input fetch_pkg::addr_t aligned);
		return {(aligned + 32'd4) ^ KEY, aligned ^ KEY};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// All bus outputs change on the falling edge
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		fetch_pkg::addr_t addr;
		int delay;
		o_arready = 1'b0;
		o_rvalid = 1'b0;
		o_rdata = '0;
		o_rresp = 2'b00;
		cycle = 0;
		forever
		begin
			@(negedge S_AXI_ACLK);
			cycle = cycle + 1;
			if (!S_AXI_ARESETN)
			begin
				pend_addr.delete();
				pend_due.delete();
				o_arready = 1'b0;
				o_rvalid = 1'b0;
			end
			else
			begin
				// In order and at most one reply per cycle
				if (pend_due.size() > 0 && pend_due[0] <= cycle)
				begin
					addr = pend_addr.pop_front();
					void'(pend_due.pop_front());
					o_rvalid = 1'b1;
					o_rdata = word_for(addr);
					// SLVERR on the chosen word
					o_rresp = (i_err_en && addr == i_err_addr) ? 2'b10 : 2'b00;
				end
				else
				begin
					o_rvalid = 1'b0;
					o_rdata = '0;
					o_rresp = 2'b00;
				end
				o_arready = i_random ? 1'($urandom % 4 != 0) : 1'b1;
				// Handshake happens on the coming rising edge
				if (i_arvalid && o_arready)
				begin
					delay = i_random ? int'($urandom % 4) : 0;
					pend_addr.push_back({i_araddr[fetch_pkg::ADDR_W-1:fetch_pkg::AXIL_LSB],
						{fetch_pkg::AXIL_LSB{1'b0}}});
					pend_due.push_back(cycle + 1 + delay);
				end
			end
		end
	end

endmodule

`default_nettype wire
